/* hw/wiscPkg.sv */
// shared types for the execute subsystem
// opcode table, function codes and branch conditions
// instruction word union with R, I and branch views
// stage structs passed decode -> execute -> result
package wiscPkg;

    localparam int dataWidth = 16;

    typedef enum logic [4:0] {
        opJ     = 5'b00100,
        opJr    = 5'b00101,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opBltz  = 5'b01110,
        opBgez  = 5'b01111,
        opBtr   = 5'b11001,
        opR     = 5'b11011,
        opSet   = 5'b11100
    } opcodeE;

    // func field, meaning depends on opcode
    typedef logic [1:0] funcE;

    localparam funcE funcAdd  = 2'd0;  // opR
    localparam funcE funcSub  = 2'd1;
    localparam funcE funcXor  = 2'd2;
    localparam funcE funcAndn = 2'd3;

    localparam funcE setSeq = 2'd0;    // opSet
    localparam funcE setSlt = 2'd1;
    localparam funcE setSle = 2'd2;
    localparam funcE setSco = 2'd3;

    localparam funcE condEqz = 2'd0;   // branch test on opA
    localparam funcE condNez = 2'd1;
    localparam funcE condLtz = 2'd2;
    localparam funcE condGez = 2'd3;

    typedef union packed {
        struct packed {
            opcodeE     opcode;
            logic [2:0] rs;
            logic [2:0] rt;
            logic [2:0] rd;
            funcE       func;
        } rType;
        struct packed {
            opcodeE     opcode;
            logic [2:0] rs;
            logic [2:0] rd;
            logic [4:0] imm;
        } iType;
        struct packed {
            opcodeE     opcode;
            logic [2:0] rs;
            logic [7:0] imm;
        } bType;
    } instrU;

    typedef enum logic [1:0] {
        aluAdd  = 2'd0,
        aluXor  = 2'd1,
        aluAndn = 2'd2
    } aluOpE;

    typedef struct packed {
        aluOpE      aluOp;
        logic       invA;
        logic       invB;
        logic       cin;
        logic       useImm;
        logic       isSet;
        logic       isBtr;
        logic       isBranch;
        logic       isJump;
        logic       isJumpReg;
        funcE       branchCond;
        funcE       setSel;
        logic       writeEn;
        logic [2:0] destReg;
    } ctrlT;

    typedef struct packed {
        ctrlT                 ctrl;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] imm;    // already sign-extended
        logic [dataWidth-1:0] incPc;
        logic                 valid;
    } decodedT;

    typedef struct packed {
        logic [dataWidth-1:0] aluResult;
        logic                 setResult;
        logic [dataWidth-1:0] reversed;
        logic                 branchTaken;
        logic [dataWidth-1:0] offsetAddr;
        ctrlT                 ctrl;
        logic [dataWidth-1:0] incPc;
        logic                 valid;
    } execT;

endpackage

/* hw/alu.sv */
// 16-bit ALU
// optional inversion of either operand, carry-in
// add, xor and and-not, with signed overflow and zero flags
`timescale 1ns/10ps

module alu import wiscPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluOpE                op,
    input  logic                 invA,
    input  logic                 invB,
    input  logic                 cin,
    output logic [dataWidth-1:0] y,
    output logic                 ofl,
    output logic                 zero
);

    logic [dataWidth-1:0] aIn, bIn;
    logic [dataWidth-1:0] sum;
    logic                 sameSign;

    assign aIn = invA ? ~a : a;
    assign bIn = invB ? ~b : b;

    assign sum = aIn + bIn + {{(dataWidth-1){1'b0}}, cin};

    always_comb begin
        case (op)
            aluXor:  y = aIn ^ bIn;
            aluAndn: y = aIn & ~bIn;
            default: y = sum;
        endcase
    end

    // overflow only when both inputs agree in sign and the sum flips it
    assign sameSign = (aIn[dataWidth-1] == bIn[dataWidth-1]);
    assign ofl  = (op == aluAdd) && sameSign && (sum[dataWidth-1] != aIn[dataWidth-1]);
    assign zero = ~|y;

endmodule

/* hw/instrDecode.sv */
// instruction decode stage
// turns the opcode into ALU and flow control bits
// selects and sign-extends the immediate, forms pc + 2
`timescale 1ns/10ps

module instrDecode import wiscPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  instrU                instr,
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic [dataWidth-1:0] pc,
    input  logic                 instrValid,
    output decodedT              decoded
);

    ctrlT                 ctrlD, ctrlQ;
    logic                 validQ;
    logic                 useImm8;      // branch/jump forms take the 8-bit field
    logic [dataWidth-1:0] immD;
    logic [dataWidth-1:0] opAQ, opBQ, immQ, incPcQ;

    always_comb begin
        ctrlD = '0;
        ctrlD.aluOp = aluAdd;
        useImm8 = 1'b0;
        case (instr.rType.opcode)
            opR: begin
                ctrlD.writeEn = 1'b1;
                ctrlD.destReg = instr.rType.rd;
                case (instr.rType.func)
                    funcAdd:  ctrlD.aluOp = aluAdd;
                    funcSub:  begin
                        ctrlD.invB = 1'b1;    // a + ~b + 1
                        ctrlD.cin  = 1'b1;
                    end
                    funcXor:  ctrlD.aluOp = aluXor;
                    funcAndn: ctrlD.aluOp = aluAndn;
                endcase
            end
            opAddi, opSubi, opXori: begin
                ctrlD.useImm  = 1'b1;
                ctrlD.writeEn = 1'b1;
                ctrlD.destReg = instr.iType.rd;
                if (instr.iType.opcode == opSubi) begin
                    ctrlD.invB = 1'b1;
                    ctrlD.cin  = 1'b1;
                end
                if (instr.iType.opcode == opXori)
                    ctrlD.aluOp = aluXor;
            end
            opSet: begin
                ctrlD.isSet   = 1'b1;
                ctrlD.setSel  = instr.rType.func;
                ctrlD.writeEn = 1'b1;
                ctrlD.destReg = instr.rType.rd;
                // compares subtract, sco is a plain add
                if (instr.rType.func != setSco) begin
                    ctrlD.invB = 1'b1;
                    ctrlD.cin  = 1'b1;
                end
            end
            opBtr: begin
                ctrlD.isBtr   = 1'b1;
                ctrlD.writeEn = 1'b1;
                ctrlD.destReg = instr.rType.rd;
            end
            opBeqz, opBnez, opBltz, opBgez: begin
                ctrlD.isBranch = 1'b1;
                useImm8 = 1'b1;
                case (instr.bType.opcode)
                    opBeqz:  ctrlD.branchCond = condEqz;
                    opBnez:  ctrlD.branchCond = condNez;
                    opBltz:  ctrlD.branchCond = condLtz;
                    default: ctrlD.branchCond = condGez;
                endcase
            end
            opJ: begin
                ctrlD.isJump = 1'b1;
                useImm8 = 1'b1;
            end
            opJr: begin
                ctrlD.isJumpReg = 1'b1;
                ctrlD.useImm    = 1'b1;    // ALU forms opA + imm
                useImm8 = 1'b1;
            end
            default: ;                     // unknown opcode does nothing
        endcase
    end

    assign immD = useImm8 ? {{8{instr.bType.imm[7]}}, instr.bType.imm}
                          : {{11{instr.iType.imm[4]}}, instr.iType.imm};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlQ  <= '0;
            validQ <= 1'b0;
        end else begin
            ctrlQ  <= ctrlD;
            validQ <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        opAQ   <= opA;
        opBQ   <= opB;
        immQ   <= immD;
        incPcQ <= pc + 16'd2;    // byte addressed, two bytes per word
    end

    assign decoded = '{ctrl: ctrlQ, opA: opAQ, opB: opBQ, imm: immQ,
                       incPc: incPcQ, valid: validQ};

endmodule

/* hw/execute.sv */
// execute stage, purely combinational
// ALU operand select, set bit, bit reverse of opA
// branch condition on opA and the pc-relative target
`timescale 1ns/10ps

module execute import wiscPkg::*; (
    input  decodedT decoded,
    output execT    exec
);

    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluY;
    logic                 aluOfl, aluZero;

    assign aluB = decoded.ctrl.useImm ? decoded.imm : decoded.opB;

    alu mainAlu (
        .a    (decoded.opA),
        .b    (aluB),
        .op   (decoded.ctrl.aluOp),
        .invA (decoded.ctrl.invA),
        .invB (decoded.ctrl.invB),
        .cin  (decoded.ctrl.cin),
        .y    (aluY),
        .ofl  (aluOfl),
        .zero (aluZero)
    );

    always_comb begin
        logic condMet;
        exec.aluResult = aluY;
        case (decoded.ctrl.setSel)
            setSeq:  exec.setResult = aluZero;
            setSlt:  exec.setResult = aluY[dataWidth-1];             // sign of a - b
            setSle:  exec.setResult = aluY[dataWidth-1] | aluZero;
            default: exec.setResult = aluOfl;                        // sco
        endcase
        for (int i = 0; i < dataWidth; i++)
            exec.reversed[i] = decoded.opA[dataWidth-1-i];
        case (decoded.ctrl.branchCond)
            condEqz: condMet = (decoded.opA == '0);
            condNez: condMet = (decoded.opA != '0);
            condLtz: condMet = decoded.opA[dataWidth-1];
            default: condMet = ~decoded.opA[dataWidth-1];            // gez
        endcase
        exec.branchTaken = decoded.ctrl.isBranch & condMet;
        exec.offsetAddr  = decoded.incPc + decoded.imm;              // no shift, byte aligned
        exec.ctrl        = decoded.ctrl;
        exec.incPc       = decoded.incPc;
        exec.valid       = decoded.valid;
    end

endmodule

/* hw/resultStage.sv */
// result stage
// picks the writeback value and the next pc
// registers them with destination, write enable and valid
`timescale 1ns/10ps

module resultStage import wiscPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  execT                 exec,
    output logic [dataWidth-1:0] result,
    output logic [dataWidth-1:0] nextPc,
    output logic [2:0]           destReg,
    output logic                 writeEn,
    output logic                 resultValid
);

    logic [dataWidth-1:0] resultD;
    logic [dataWidth-1:0] nextPcD;

    always_comb begin
        if (exec.ctrl.isBtr)
            resultD = exec.reversed;
        else if (exec.ctrl.isSet)
            resultD = {{(dataWidth-1){1'b0}}, exec.setResult};
        else
            resultD = exec.aluResult;
    end

    // jr target comes out of the ALU as opA + imm
    always_comb begin
        if (exec.ctrl.isJumpReg)
            nextPcD = exec.aluResult;
        else if (exec.branchTaken || exec.ctrl.isJump)
            nextPcD = exec.offsetAddr;
        else
            nextPcD = exec.incPc;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            writeEn     <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            writeEn     <= exec.valid & exec.ctrl.writeEn;
            resultValid <= exec.valid;
        end
    end

    // outputs hold between valid instructions
    always_ff @(posedge clk) begin
        if (!rstN) begin
            result  <= '0;
            nextPc  <= '0;
            destReg <= '0;
        end else if (exec.valid) begin
            result  <= resultD;
            nextPc  <= nextPcD;
            destReg <= exec.ctrl.destReg;
        end
    end

endmodule

/* hw/wiscExecTop.sv */
// execute subsystem top
// decode -> execute -> result, two cycles from instr to result
`timescale 1ns/10ps

module wiscExecTop import wiscPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  instrU                instr,
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    input  logic [dataWidth-1:0] pc,
    input  logic                 instrValid,
    output logic [dataWidth-1:0] result,
    output logic [dataWidth-1:0] nextPc,
    output logic [2:0]           destReg,
    output logic                 writeEn,
    output logic                 resultValid
);

    decodedT decoded;
    execT    exec;

    instrDecode decodeStage (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .opA        (opA),
        .opB        (opB),
        .pc         (pc),
        .instrValid (instrValid),
        .decoded    (decoded)
    );

    execute executeStage (.decoded (decoded), .exec (exec));

    resultStage writeStage (
        .clk         (clk),
        .rstN        (rstN),
        .exec        (exec),
        .result      (result),
        .nextPc      (nextPc),
        .destReg     (destReg),
        .writeEn     (writeEn),
        .resultValid (resultValid)
    );

endmodule

/* test/wiscExecVectors.svh */
// vector table for the execute subsystem testbench
// each row gives name, instr, opA, opB, pc, then expected result, nextPc, destReg, writeEn
// result and destReg only count when writeEn is expected high
`ifndef wiscExecVectorsSvh
`define wiscExecVectorsSvh

    task automatic loadVectors();
        // R format, rs r1, rt r2
        addVector("add",      16'hd94c, 16'h1234, 16'h0f0f, 16'h0100, 16'h2143, 16'h0102, 3, 1);
        addVector("add ovf",  16'hd950, 16'h7fff, 16'h0001, 16'h0102, 16'h8000, 16'h0104, 4, 1);
        addVector("sub",      16'hd955, 16'h0005, 16'h0007, 16'h0104, 16'hfffe, 16'h0106, 5, 1);
        addVector("xor",      16'hd95a, 16'haaaa, 16'h0ff0, 16'h0106, 16'ha55a, 16'h0108, 6, 1);
        addVector("andn",     16'hd95f, 16'hf0f0, 16'h3c3c, 16'h0108, 16'hc0c0, 16'h010a, 7, 1);
        // immediates are five bits, sign-extended
        addVector("addi",     16'h4147, 16'h0010, 16'h0000, 16'h010a, 16'h0017, 16'h010c, 2, 1);
        addVector("addi neg", 16'h413f, 16'h0000, 16'h0000, 16'h010c, 16'hffff, 16'h010e, 1, 1);
        addVector("subi",     16'h4963, 16'h0020, 16'h0000, 16'h010e, 16'h001d, 16'h0110, 3, 1);
        addVector("subi neg", 16'h4990, 16'h7ff8, 16'h0000, 16'h0110, 16'h8008, 16'h0112, 4, 1);
        addVector("xori neg", 16'h51b5, 16'h00ff, 16'h0000, 16'h0112, 16'hff0a, 16'h0114, 5, 1);
        // set compares into r2
        addVector("seq yes",  16'he148, 16'h1234, 16'h1234, 16'h0114, 16'h0001, 16'h0116, 2, 1);
        addVector("seq no",   16'he148, 16'h1234, 16'h1235, 16'h0116, 16'h0000, 16'h0118, 2, 1);
        addVector("slt yes",  16'he149, 16'h0003, 16'h0005, 16'h0118, 16'h0001, 16'h011a, 2, 1);
        addVector("slt no",   16'he149, 16'h0005, 16'h0003, 16'h011a, 16'h0000, 16'h011c, 2, 1);
        addVector("sle yes",  16'he14a, 16'h0007, 16'h0007, 16'h011c, 16'h0001, 16'h011e, 2, 1);
        addVector("sle no",   16'he14a, 16'h0008, 16'h0007, 16'h011e, 16'h0000, 16'h0120, 2, 1);
        addVector("sco yes",  16'he14b, 16'h8000, 16'h8000, 16'h0120, 16'h0001, 16'h0122, 2, 1);
        addVector("sco no",   16'he14b, 16'h0001, 16'h0001, 16'h0122, 16'h0000, 16'h0124, 2, 1);
        addVector("btr",      16'hc918, 16'h1234, 16'h0000, 16'h0124, 16'h2c48, 16'h0126, 6, 1);
        // branches test r1, eight-bit offset from pc + 2
        addVector("beqz yes", 16'h6110, 16'h0000, 16'h0000, 16'h0200, 16'h0000, 16'h0212, 0, 0);
        addVector("beqz no",  16'h6110, 16'h0005, 16'h0000, 16'h0200, 16'h0000, 16'h0202, 0, 0);
        addVector("bnez yes", 16'h69f0, 16'h0005, 16'h0000, 16'h0300, 16'h0000, 16'h02f2, 0, 0);
        addVector("bnez no",  16'h69f0, 16'h0000, 16'h0000, 16'h0300, 16'h0000, 16'h0302, 0, 0);
        addVector("bltz yes", 16'h7108, 16'h8001, 16'h0000, 16'h0400, 16'h0000, 16'h040a, 0, 0);
        addVector("bltz no",  16'h7108, 16'h0001, 16'h0000, 16'h0400, 16'h0000, 16'h0402, 0, 0);
        addVector("bgez yes", 16'h7920, 16'h0000, 16'h0000, 16'h0500, 16'h0000, 16'h0522, 0, 0);
        addVector("bgez no",  16'h7920, 16'hffff, 16'h0000, 16'h0500, 16'h0000, 16'h0502, 0, 0);
        addVector("j fwd",    16'h2040, 16'h0000, 16'h0000, 16'h0600, 16'h0000, 16'h0642, 0, 0);
        addVector("j back",   16'h2080, 16'h0000, 16'h0000, 16'h0600, 16'h0000, 16'h0582, 0, 0);
        addVector("jr",       16'h2a04, 16'h1000, 16'h0000, 16'h0700, 16'h0000, 16'h1004, 0, 0);
        addVector("jr neg",   16'h2afe, 16'h2000, 16'h0000, 16'h0700, 16'h0000, 16'h1ffe, 0, 0);
    endtask

`endif

/* test/wiscExecTb.sv */
// testbench for the execute subsystem
// issues the vector table one instruction per cycle
// checks each result two cycles later, with timeout and summary
`timescale 1ns/10ps

module wiscExecTb import wiscPkg::*; ();

    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] nextPc;
        logic [2:0]           destReg;
        logic                 writeEn;
    } vectorT;

    logic                 clk = 1'b0;
    logic                 rstN;
    instrU                instr;
    logic [dataWidth-1:0] opA, opB, pc;
    logic                 instrValid;
    logic [dataWidth-1:0] result, nextPc;
    logic [2:0]           destReg;
    logic                 writeEn, resultValid;

    vectorT vecTable[$];
    string  vecName[$];
    int     issueCycle[$];     // cycle each entry was driven
    int     outIdx = 0;        // next entry expected at the output
    int     cycleCount = 0;
    int     cycleLimit = 1000; // tightened once the table is known
    int     passCount = 0;
    int     failCount = 0;
    int     idleFail = 0;

    wiscExecTop uut (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .opA         (opA),
        .opB         (opB),
        .pc          (pc),
        .instrValid  (instrValid),
        .result      (result),
        .nextPc      (nextPc),
        .destReg     (destReg),
        .writeEn     (writeEn),
        .resultValid (resultValid)
    );

    always #50 clk = ~clk;

    task automatic addVector(input string name,
                             input logic [dataWidth-1:0] instrW, a, b, pcW, expResult, expNextPc,
                             input int dest, input int we);
        vectorT v;
        v = '{instr: instrW, opA: a, opB: b, pc: pcW, result: expResult,
              nextPc: expNextPc, destReg: dest[2:0], writeEn: we[0]};
        vecTable.push_back(v);
        vecName.push_back(name);
    endtask

    `include "wiscExecVectors.svh"

    task automatic checkResult(input int idx);
        vectorT exp;
        bit     bad;
        exp = vecTable[idx];
        bad = 1'b0;
        if (cycleCount != issueCycle[idx] + 2) begin
            $display("%s came out %0d cycles after issue instead of 2",
                     vecName[idx], cycleCount - issueCycle[idx]);
            bad = 1'b1;
        end
        if (writeEn !== exp.writeEn) begin
            $display("FAILED %s writeEn expected %0b actual %0b", vecName[idx], exp.writeEn, writeEn);
            bad = 1'b1;
        end
        if (exp.writeEn && result !== exp.result) begin
            $display("FAILED %s result expected %h actual %h", vecName[idx], exp.result, result);
            bad = 1'b1;
        end
        if (exp.writeEn && destReg !== exp.destReg) begin
            $display("FAILED %s destReg expected %0d actual %0d", vecName[idx], exp.destReg, destReg);
            bad = 1'b1;
        end
        if (nextPc !== exp.nextPc) begin
            $display("FAILED %s nextPc expected %h actual %h", vecName[idx], exp.nextPc, nextPc);
            bad = 1'b1;
        end
        if (bad) begin
            failCount++;
        end else begin
            passCount++;
            $display("passed %s", vecName[idx]);
        end
    endtask

    // outputs settle after the rising edge, so look mid-cycle
    always @(negedge clk) begin
        if (resultValid === 1'b1) begin
            if (outIdx < vecTable.size()) begin
                checkResult(outIdx);
                outIdx++;
            end else begin
                $display("resultValid high with no instruction left in flight");
                failCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles with %0d results still missing",
                     cycleCount, vecTable.size() - outIdx);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        rstN       = 1'b0;
        instr      = '0;
        opA        = '0;
        opB        = '0;
        pc         = '0;
        instrValid = 1'b0;
        loadVectors();
        cycleLimit = vecTable.size() + 5 + 10;   // table + reset + margin
        repeat (5) @(posedge clk);
        #5;
        rstN = 1'b1;

        @(negedge clk);                           // nothing issued yet
        if (resultValid !== 1'b0 || writeEn !== 1'b0) begin
            $display("FAILED idle after reset expected 0 0 actual %b %b", resultValid, writeEn);
            idleFail = 1;
        end else begin
            $display("passed idle after reset");
        end

        for (int i = 0; i < vecTable.size(); i++) begin
            @(posedge clk);
            #5;
            instr      = vecTable[i].instr;
            opA        = vecTable[i].opA;
            opB        = vecTable[i].opB;
            pc         = vecTable[i].pc;
            instrValid = 1'b1;
            issueCycle.push_back(cycleCount);
        end
        @(posedge clk);
        #5;
        instrValid = 1'b0;

        wait (outIdx == vecTable.size());
        repeat (3) @(negedge clk);                // any extra result shows up here
        $display("tests passed %0d failed %0d", passCount + 1 - idleFail, failCount + idleFail);
        if (failCount + idleFail == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+test
hw/wiscPkg.sv
hw/alu.sv
hw/instrDecode.sv
hw/execute.sv
hw/resultStage.sv
hw/wiscExecTop.sv
test/wiscExecTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the execute subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module wiscExecTb -f vlog.f -o wiscExecSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/wiscExecSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
